// ==== Makefile ====
# Verilator build and run of the core testbench

VERILATOR ?= verilator
TOP       ?= proc_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
SIMFLAGS  ?= +verilator+error+limit+1000

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIMFLAGS))"; echo "$$out"; \
	  echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== sim.f ====
verilog/isa_pkg.sv
verilog/pipe_pkg.sv
verilog/stage_reg.sv
verilog/reg_file.sv
verilog/exec_alu.sv
verilog/proc_ctrl.sv
verilog/proc_top.sv
tb/proc_properties.sv
tb/proc_tb.sv

// ==== tb/proc_properties.sv ====
`timescale 1ns/100ps
`default_nettype none
// --------------------------------------------------
// concurrent checks on the proc_top stream ports
// bound into every proc_top instance
// --------------------------------------------------

module proc_properties (
  input wire logic           clk,
  input wire logic           reset,
  input wire logic           inst_rdy,
  input wire logic           mngr2proc_rdy,
  input wire isa_pkg::word_t proc2mngr_msg,
  input wire logic           proc2mngr_val,
  input wire logic           proc2mngr_rdy,
  input wire logic           commit
);

  // failed checks so far
  int fail_count = 0;

  // no outputs while reset is applied and in the first cycle after
  reset_quiet: assert property (@(posedge clk)
    reset |=> (!proc2mngr_val && !mngr2proc_rdy && !commit))
    else begin
      $error("stream valid, mngr2proc_rdy or commit high around reset");
      fail_count++;
    end

  // empty D accepts straight away
  ready_after_reset: assert property (@(posedge clk) $fell(reset) |-> inst_rdy)
    else begin
      $error("inst_rdy low in the first cycle after reset");
      fail_count++;
    end

  // an output not taken stays put
  p2m_hold: assert property (@(posedge clk) disable iff (reset)
    (proc2mngr_val && !proc2mngr_rdy) |=> (proc2mngr_val && $stable(proc2mngr_msg)))
    else begin
      $error("proc2mngr dropped or changed before proc2mngr_rdy");
      fail_count++;
    end

endmodule

bind proc_top proc_properties props (
  .clk, .reset, .inst_rdy, .mngr2proc_rdy,
  .proc2mngr_msg, .proc2mngr_val, .proc2mngr_rdy, .commit
);

`default_nettype wire

// ==== tb/proc_tb.sv ====
`timescale 1ns/100ps
`default_nettype none
// --------------------------------------------------
// testbench for proc_top: instruction programs checked against a register
// model, manager stream models with random gaps, per-test report, watchdog
// --------------------------------------------------

module proc_tb;

  localparam int num_cores = 4;
  localparam int core_id   = 2;

  // RV32I major opcodes
  localparam logic [6:0] op_op     = 7'b0110011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_system = 7'b1110011;

  // {funct7, funct3}: add sub sll slt sltu xor srl sra or and
  localparam logic [9:0] rr_ops [10] = '{10'h000, 10'h100, 10'h001, 10'h002, 10'h003,
                                         10'h004, 10'h005, 10'h105, 10'h006, 10'h007};

  logic        clk           = 1'b0;
  logic        reset         = 1'b1;
  logic [31:0] inst          = '0;
  logic        inst_val      = 1'b0;
  logic        inst_rdy;
  logic [31:0] mngr2proc_msg = '0;
  logic        mngr2proc_val = 1'b0;
  logic        mngr2proc_rdy;
  logic [31:0] proc2mngr_msg;
  logic        proc2mngr_val;
  logic        proc2mngr_rdy = 1'b0;
  logic        commit;

  // register model and stream queues
  logic [31:0] model_rf [32];
  logic [31:0] inst_q [$];
  logic [31:0] m2p_q [$];
  logic [31:0] exp_q [$];
  logic [31:0] exp_word;

  // gap chance in percent for each stream
  int inst_gap     = 0;
  int m2p_gap      = 0;
  int p2m_gap      = 0;
  int issued       = 0;
  int commits      = 0;
  int test_len     = 0;
  int errors       = 0;
  int checked      = 0;
  int tests_run    = 0;
  int cycles       = 0;
  // covers reset, each test adds its own share
  int limit_cycles = 16;

  always #4 clk = ~clk;

  proc_top #(.num_cores(num_cores), .core_id(core_id)) proc_top_inst (
    .clk, .reset, .inst, .inst_val, .inst_rdy,
    .mngr2proc_msg, .mngr2proc_val, .mngr2proc_rdy,
    .proc2mngr_msg, .proc2mngr_val, .proc2mngr_rdy, .commit
  );

  // --------------------------------------------------
  // reference rules and program builders
  // --------------------------------------------------

  function automatic logic [31:0] alu_expect(input logic [9:0] op, input logic [31:0] a,
                                             input logic [31:0] b);
    logic [4:0] sh;
    sh = b[4:0];
    case (op)
      10'h000: return a + b;
      10'h100: return a - b;
      10'h001: return a << sh;
      10'h002: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      10'h003: return (a < b) ? 32'd1 : 32'd0;
      10'h004: return a ^ b;
      10'h005: return a >> sh;
      10'h105: return $unsigned($signed(a) >>> sh);
      10'h006: return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic emit_inst(input logic [31:0] word);
    inst_q.push_back(word);
    issued++;
    test_len++;
  endtask

  task automatic read_csr(input int rd, input logic [11:0] csr, input logic [31:0] value);
    emit_inst({csr, 5'd0, 3'b010, 5'(rd), op_system});
    if (rd != 0) begin
      model_rf[rd] = value;
    end
  endtask

  // csrr rd, mngr2proc with the word the manager will send
  task automatic load_reg(input int rd, input logic [31:0] value);
    m2p_q.push_back(value);
    read_csr(rd, 12'hFC0, value);
  endtask

  // csrw proc2mngr, rs1
  task automatic write_out(input int rs1);
    exp_q.push_back(model_rf[rs1]);
    emit_inst({12'h7C0, 5'(rs1), 3'b001, 5'd0, op_system});
  endtask

  task automatic exec_rr(input logic [9:0] op, input int rd, input int rs1, input int rs2);
    emit_inst({op[9:3], 5'(rs2), 5'(rs1), op[2:0], 5'(rd), op_op});
    if (rd != 0) begin
      model_rf[rd] = alu_expect(op, model_rf[rs1], model_rf[rs2]);
    end
  endtask

  task automatic exec_addi(input int rd, input int rs1, input logic [11:0] imm);
    emit_inst({imm, 5'(rs1), 3'b000, 5'(rd), op_imm});
    if (rd != 0) begin
      model_rf[rd] = model_rf[rs1] + {{20{imm[11]}}, imm};
    end
  endtask

  // programs are built away from the rising edge
  task automatic begin_test(input int gap_inst, input int gap_m2p, input int gap_p2m);
    @(negedge clk);
    inst_gap = gap_inst;
    m2p_gap  = gap_m2p;
    p2m_gap  = gap_p2m;
    test_len = 0;
  endtask

  task automatic run_test(input string name, input int n_inst);
    int err_before;
    err_before   = errors + proc_top_inst.props.fail_count;
    limit_cycles = limit_cycles + 4 * n_inst * 40;
    while (commits < issued) begin
      @(posedge clk);
    end
    @(posedge clk);
    assert (m2p_q.size() == 0 && exp_q.size() == 0 && commits == issued) else begin
      $display("test %s left %0d mngr2proc words unread, %0d outputs missing, %0d of %0d commits",
               name, m2p_q.size(), exp_q.size(), commits, issued);
      errors++;
    end
    tests_run++;
    $display("test %-10s %3d instructions  %s", name, n_inst,
             (errors + proc_top_inst.props.fail_count == err_before) ? "ok" : "with errors");
  endtask

  // --------------------------------------------------
  // stream models, all driven on the rising edge
  // --------------------------------------------------

  task automatic check_output();
    assert (exp_q.size() > 0) else begin
      $display("unexpected word %h on proc2mngr_msg at %0t, nothing was expected",
               proc2mngr_msg, $time);
      errors++;
    end
    if (exp_q.size() > 0) begin
      exp_word = exp_q.pop_front();
      checked++;
      assert (proc2mngr_msg == exp_word) else begin
        $display("Fail time=%0t proc2mngr_msg expected=%h actual=%h",
                 $time, exp_word, proc2mngr_msg);
        errors++;
      end
    end
  endtask

  always @(posedge clk) begin
    // instruction stream, val held until taken
    if (inst_val && inst_rdy) begin
      void'(inst_q.pop_front());
    end
    if (!inst_val || inst_rdy) begin
      if (inst_q.size() > 0 && int'($urandom_range(99)) >= inst_gap) begin
        inst_val <= 1'b1;
        inst     <= inst_q[0];
      end else begin
        inst_val <= 1'b0;
      end
    end
    // mngr2proc source
    if (mngr2proc_val && mngr2proc_rdy) begin
      void'(m2p_q.pop_front());
    end
    if (!mngr2proc_val || mngr2proc_rdy) begin
      if (m2p_q.size() > 0 && int'($urandom_range(99)) >= m2p_gap) begin
        mngr2proc_val <= 1'b1;
        mngr2proc_msg <= m2p_q[0];
      end else begin
        mngr2proc_val <= 1'b0;
      end
    end
    // proc2mngr sink
    if (!reset && proc2mngr_val && proc2mngr_rdy) begin
      check_output();
    end
    proc2mngr_rdy <= int'($urandom_range(99)) >= p2m_gap;
  end

  always @(posedge clk) begin
    if (!reset && commit) begin
      commits <= commits + 1;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > limit_cycles) begin
      $display("watchdog expired after %0d cycles, the core stopped committing", cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  // --------------------------------------------------
  // test sequence
  // --------------------------------------------------

  initial begin
    foreach (model_rf[i]) begin
      model_rf[i] = '0;
    end
    void'($urandom(29912));
    repeat (3) @(posedge clk);
    reset <= 1'b0;

    begin_test(0, 0, 0);
    write_out(0);
    exec_addi(5, 0, 12'h123);
    write_out(5);
    run_test("reset", test_len);

    begin_test(0, 0, 0);
    repeat (2) begin
      foreach (rr_ops[i]) begin
        load_reg(1, $urandom());
        load_reg(2, $urandom());
        exec_rr(rr_ops[i], 3, 1, 2);
        write_out(3);
      end
      load_reg(1, $urandom());
      exec_addi(3, 1, 12'($urandom()));
      write_out(3);
    end
    run_test("alu", test_len);

    // chains on one register hit the X and then the W hazard
    begin_test(0, 0, 0);
    load_reg(4, $urandom());
    repeat (6) begin
      exec_addi(4, 4, 12'($urandom()));
    end
    exec_rr(10'h000, 5, 4, 4);
    exec_rr(10'h100, 4, 5, 4);
    exec_rr(10'h004, 4, 4, 5);
    write_out(4);
    write_out(5);
    run_test("dependent", test_len);

    begin_test(10, 60, 0);
    for (int i = 1; i <= 8; i++) begin
      load_reg(i, $urandom());
    end
    for (int i = 1; i <= 8; i++) begin
      write_out(i);
    end
    repeat (6) begin
      load_reg(9, $urandom());
      write_out(9);
    end
    run_test("m2p_gaps", test_len);

    begin_test(20, 20, 70);
    repeat (10) begin
      load_reg(10, $urandom());
      exec_addi(11, 10, 12'h005);
      write_out(10);
      write_out(11);
    end
    run_test("backpress", test_len);

    // identity CSRs, then three encodings that must leave x8 alone
    begin_test(0, 0, 0);
    read_csr(6, 12'hFC1, 32'd4);
    write_out(6);
    read_csr(7, 12'hF14, 32'd2);
    write_out(7);
    load_reg(8, $urandom());
    emit_inst({7'h01, 5'd2, 5'd1, 3'b000, 5'd8, op_op});
    emit_inst({12'h123, 5'd0, 3'b010, 5'd8, op_system});
    emit_inst(32'hFFFF_FFFF);
    write_out(8);
    run_test("csr_noop", test_len);

    $display("summary: %0d tests, %0d outputs checked, %0d check errors, %0d property failures",
             tests_run, checked, errors, proc_top_inst.props.fail_count);
    if (errors == 0 && proc_top_inst.props.fail_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/exec_alu.sv ====
`timescale 1ns/100ps
`default_nettype none
// ------------------------------------------------
// X stage: second operand select and ALU, purely combinational
// ------------------------------------------------

module exec_alu #(
  parameter int num_cores = 1,
  parameter int core_id   = 0
) (
  input  wire pipe_pkg::x_payload_t x_item,
  output isa_pkg::word_t            result
);

  isa_pkg::word_t op1;
  isa_pkg::word_t op2;
  logic [4:0]     shamt;

  assign op1   = x_item.op1;
  assign shamt = op2[4:0];

  // op2 source
  always_comb begin
    case (x_item.ctrl.op2_sel)
      isa_pkg::op2_reg: op2 = x_item.rs2;
      isa_pkg::op2_imm: op2 = x_item.imm;
      default: begin
        // identity CSRs come from parameters, anything else is mngr2proc
        if (x_item.imm[11:0] == isa_pkg::csr_numcores) begin
          op2 = isa_pkg::word_t'(num_cores);
        end else if (x_item.imm[11:0] == isa_pkg::csr_coreid) begin
          op2 = isa_pkg::word_t'(core_id);
        end else begin
          op2 = x_item.csr;
        end
      end
    endcase
  end

  always_comb begin
    case (x_item.ctrl.alu_fn)
      isa_pkg::alu_add:    result = op1 + op2;
      isa_pkg::alu_sub:    result = op1 - op2;
      isa_pkg::alu_and:    result = op1 & op2;
      isa_pkg::alu_or:     result = op1 | op2;
      isa_pkg::alu_xor:    result = op1 ^ op2;
      isa_pkg::alu_slt:    result = {{(isa_pkg::xlen-1){1'b0}}, $signed(op1) < $signed(op2)};
      isa_pkg::alu_sltu:   result = {{(isa_pkg::xlen-1){1'b0}}, op1 < op2};
      isa_pkg::alu_sll:    result = op1 << shamt;
      isa_pkg::alu_srl:    result = op1 >> shamt;
      isa_pkg::alu_sra:    result = $signed(op1) >>> shamt;
      // csrw
      isa_pkg::alu_cp_op1: result = op1;
      // csrr
      isa_pkg::alu_cp_op2: result = op2;
      default:             result = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== verilog/isa_pkg.sv ====
`default_nettype none
// ------------------------------------------------
// instruction set definitions for the core: word types, opcodes,
// funct fields, ALU functions and manager CSR numbers
// ------------------------------------------------

package isa_pkg;

  parameter int xlen = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [31:0]     inst_t;
  typedef logic [4:0]      reg_addr_t;
  typedef logic [11:0]     csr_addr_t;
  typedef logic [6:0]      opcode_t;
  typedef logic [2:0]      funct3_t;

  // major opcodes, only these three are decoded
  parameter opcode_t opcode_op     = 7'b0110011;
  parameter opcode_t opcode_op_imm = 7'b0010011;
  parameter opcode_t opcode_system = 7'b1110011;

  // funct3 for OP and OP-IMM
  parameter funct3_t f3_add_sub = 3'b000;
  parameter funct3_t f3_sll     = 3'b001;
  parameter funct3_t f3_slt     = 3'b010;
  parameter funct3_t f3_sltu    = 3'b011;
  parameter funct3_t f3_xor     = 3'b100;
  parameter funct3_t f3_srl_sra = 3'b101;
  parameter funct3_t f3_or      = 3'b110;
  parameter funct3_t f3_and     = 3'b111;

  // funct3 for SYSTEM: csrw is csrrw, csrr is csrrs
  parameter funct3_t f3_csrrw = 3'b001;
  parameter funct3_t f3_csrrs = 3'b010;

  // funct7 selects sub and sra
  parameter logic [6:0] funct7_base = 7'b0000000;
  parameter logic [6:0] funct7_alt  = 7'b0100000;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_slt,
    alu_sltu, alu_sll, alu_srl, alu_sra, alu_cp_op1, alu_cp_op2
  } alu_fn_t;

  typedef enum logic [1:0] {op2_reg, op2_imm, op2_csr} op2_sel_t;

  // manager CSR numbers
  parameter csr_addr_t csr_mngr2proc = 12'hFC0;
  parameter csr_addr_t csr_proc2mngr = 12'h7C0;
  parameter csr_addr_t csr_numcores  = 12'hFC1;
  parameter csr_addr_t csr_coreid    = 12'hF14;

endpackage

`default_nettype wire

// ==== verilog/pipe_pkg.sv ====
`default_nettype none
// ------------------------------------------------
// pipeline structures: decoded control and the item held in X and W
// ------------------------------------------------

package pipe_pkg;

  // control produced by the decode table in D
  typedef struct packed {
    isa_pkg::alu_fn_t  alu_fn;
    isa_pkg::op2_sel_t op2_sel;
    logic              rf_wen;
    // csrr of mngr2proc, consumes one stream word
    logic              mngr2proc_rd;
    // csrw of proc2mngr, sends the result from W
    logic              proc2mngr_wr;
  } dec_ctrl_t;

  // item held in X
  typedef struct packed {
    dec_ctrl_t          ctrl;
    isa_pkg::reg_addr_t waddr;
    isa_pkg::word_t     op1;
    isa_pkg::word_t     rs2;
    // sign-extended I immediate, low 12 bits double as the CSR number
    isa_pkg::word_t     imm;
    // mngr2proc word captured when D advanced
    isa_pkg::word_t     csr;
  } x_payload_t;

  // item held in W
  typedef struct packed {
    isa_pkg::reg_addr_t waddr;
    logic               rf_wen;
    logic               proc2mngr_wr;
    isa_pkg::word_t     result;
  } w_payload_t;

endpackage

`default_nettype wire

// ==== verilog/proc_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none
// ------------------------------------------------
// control unit with the D register, decode table, stage valids, stalls
// and every stream handshake
// the datapath only follows its enables
// ------------------------------------------------

module proc_ctrl (
  input  wire logic                clk,
  input  wire logic                reset,
  input  wire isa_pkg::inst_t      inst,
  input  wire logic                inst_val,
  output logic                     inst_rdy,
  input  wire logic                mngr2proc_val,
  output logic                     mngr2proc_rdy,
  input  wire logic                proc2mngr_rdy,
  output logic                     proc2mngr_val,
  output logic                     commit,
  output isa_pkg::inst_t           inst_d,
  output pipe_pkg::dec_ctrl_t      dec_ctrl,
  output logic                     x_en,
  output logic                     x_valid_in,
  input  wire logic                x_valid,
  input  wire isa_pkg::reg_addr_t  x_waddr,
  input  wire logic                x_rf_wen,
  output logic                     w_en,
  output logic                     w_valid_in,
  input  wire logic                w_valid,
  input  wire isa_pkg::reg_addr_t  w_waddr,
  input  wire logic                w_rf_wen,
  input  wire logic                w_proc2mngr_wr,
  output logic                     rf_wen
);

  logic val_d;
  logic rs1_en;
  logic rs2_en;
  logic ostall_d;
  logic ostall_w;
  logic stall_d;
  logic stall_x;
  logic stall_w;
  logic hazard_rs1;
  logic hazard_rs2;

  isa_pkg::opcode_t   opcode;
  isa_pkg::funct3_t   funct3;
  logic [6:0]         funct7;
  isa_pkg::reg_addr_t rs1;
  isa_pkg::reg_addr_t rs2;
  isa_pkg::csr_addr_t csr_num;

  // ------------------------------------------------
  // D stage
  // ------------------------------------------------

  // D takes a new instruction whenever it is empty or moving on
  assign inst_rdy = !stall_d;

  always_ff @(posedge clk) begin
    if (reset) begin
      val_d <= 1'b0;
    end else if (inst_rdy) begin
      val_d <= inst_val;
    end
  end

  // instruction register loads alongside the D valid bit
  always_ff @(posedge clk) begin
    if (inst_rdy) begin
      inst_d <= inst;
    end
  end

  assign opcode  = inst_d[6:0];
  assign funct3  = inst_d[14:12];
  assign funct7  = inst_d[31:25];
  assign rs1     = inst_d[19:15];
  assign rs2     = inst_d[24:20];
  assign csr_num = inst_d[31:20];

  // anything the decode table does not match falls through as a no-op
  always_comb begin
    dec_ctrl         = '0;
    dec_ctrl.alu_fn  = isa_pkg::alu_add;
    dec_ctrl.op2_sel = isa_pkg::op2_reg;
    rs1_en           = 1'b0;
    rs2_en           = 1'b0;
    case (opcode)
      isa_pkg::opcode_op: begin
        rs1_en          = 1'b1;
        rs2_en          = 1'b1;
        dec_ctrl.rf_wen = 1'b1;
        case ({funct7, funct3})
          {isa_pkg::funct7_base, isa_pkg::f3_add_sub}: dec_ctrl.alu_fn = isa_pkg::alu_add;
          {isa_pkg::funct7_alt,  isa_pkg::f3_add_sub}: dec_ctrl.alu_fn = isa_pkg::alu_sub;
          {isa_pkg::funct7_base, isa_pkg::f3_sll}:     dec_ctrl.alu_fn = isa_pkg::alu_sll;
          {isa_pkg::funct7_base, isa_pkg::f3_slt}:     dec_ctrl.alu_fn = isa_pkg::alu_slt;
          {isa_pkg::funct7_base, isa_pkg::f3_sltu}:    dec_ctrl.alu_fn = isa_pkg::alu_sltu;
          {isa_pkg::funct7_base, isa_pkg::f3_xor}:     dec_ctrl.alu_fn = isa_pkg::alu_xor;
          {isa_pkg::funct7_base, isa_pkg::f3_srl_sra}: dec_ctrl.alu_fn = isa_pkg::alu_srl;
          {isa_pkg::funct7_alt,  isa_pkg::f3_srl_sra}: dec_ctrl.alu_fn = isa_pkg::alu_sra;
          {isa_pkg::funct7_base, isa_pkg::f3_or}:      dec_ctrl.alu_fn = isa_pkg::alu_or;
          {isa_pkg::funct7_base, isa_pkg::f3_and}:     dec_ctrl.alu_fn = isa_pkg::alu_and;
          default: begin
            rs1_en          = 1'b0;
            rs2_en          = 1'b0;
            dec_ctrl.rf_wen = 1'b0;
          end
        endcase
      end
      isa_pkg::opcode_op_imm: begin
        // only addi is supported
        if (funct3 == isa_pkg::f3_add_sub) begin
          rs1_en           = 1'b1;
          dec_ctrl.rf_wen  = 1'b1;
          dec_ctrl.op2_sel = isa_pkg::op2_imm;
        end
      end
      isa_pkg::opcode_system: begin
        if (funct3 == isa_pkg::f3_csrrs) begin
          // csrr where the CSR number picks the source in X
          dec_ctrl.op2_sel = isa_pkg::op2_csr;
          dec_ctrl.alu_fn  = isa_pkg::alu_cp_op2;
          case (csr_num)
            isa_pkg::csr_mngr2proc: begin
              dec_ctrl.rf_wen       = 1'b1;
              dec_ctrl.mngr2proc_rd = 1'b1;
            end
            isa_pkg::csr_numcores,
            isa_pkg::csr_coreid: dec_ctrl.rf_wen = 1'b1;
            default: dec_ctrl.rf_wen = 1'b0;
          endcase
        end else if (funct3 == isa_pkg::f3_csrrw &&
                     csr_num == isa_pkg::csr_proc2mngr) begin
          // csrw passes rs1 through as op1
          rs1_en                = 1'b1;
          dec_ctrl.alu_fn       = isa_pkg::alu_cp_op1;
          dec_ctrl.proc2mngr_wr = 1'b1;
        end
      end
      default: ;
    endcase
  end

  // ------------------------------------------------
  // stalls
  // ------------------------------------------------

  // RAW on a register still in X or W with no bypass
  // x0 never conflicts
  assign hazard_rs1 = rs1_en && rs1 != '0 &&
                      ((x_valid && x_rf_wen && x_waddr == rs1) ||
                       (w_valid && w_rf_wen && w_waddr == rs1));
  assign hazard_rs2 = rs2_en && rs2 != '0 &&
                      ((x_valid && x_rf_wen && x_waddr == rs2) ||
                       (w_valid && w_rf_wen && w_waddr == rs2));

  assign ostall_d = val_d && (hazard_rs1 || hazard_rs2 ||
                              (dec_ctrl.mngr2proc_rd && !mngr2proc_val));
  assign ostall_w = w_valid && w_proc2mngr_wr && !proc2mngr_rdy;

  // stalls travel backwards
  // an empty stage never holds up the one behind
  assign stall_w = ostall_w;
  assign stall_x = x_valid && stall_w;
  assign stall_d = val_d && (ostall_d || stall_x);

  // ------------------------------------------------
  // stage enables and handshakes
  // ------------------------------------------------

  assign x_en       = !stall_x;
  assign x_valid_in = val_d && !stall_d;
  assign w_en       = !stall_w;
  assign w_valid_in = x_valid && !stall_x;

  // word is consumed only as the csrr leaves D
  assign mngr2proc_rdy = val_d && dec_ctrl.mngr2proc_rd && !stall_d;

  // held from W until the manager takes it
  assign proc2mngr_val = w_valid && w_proc2mngr_wr;

  assign rf_wen = w_valid && w_rf_wen && !stall_w;
  assign commit = w_valid && !stall_w;

endmodule

`default_nettype wire

// ==== verilog/proc_top.sv ====
`timescale 1ns/100ps
`default_nettype none
// ------------------------------------------------
// three-stage core D/X/W: control unit, register file, ALU and two
// stage registers; instructions and manager traffic are val/rdy streams
// ------------------------------------------------

module proc_top #(
  parameter int num_cores = 1,
  parameter int core_id   = 0
) (
  input  wire logic           clk,
  input  wire logic           reset,
  input  wire isa_pkg::inst_t inst,
  input  wire logic           inst_val,
  output logic                inst_rdy,
  input  wire isa_pkg::word_t mngr2proc_msg,
  input  wire logic           mngr2proc_val,
  output logic                mngr2proc_rdy,
  output isa_pkg::word_t      proc2mngr_msg,
  output logic                proc2mngr_val,
  input  wire logic           proc2mngr_rdy,
  output logic                commit
);

  isa_pkg::inst_t       inst_d;
  pipe_pkg::dec_ctrl_t  dec_ctrl;
  pipe_pkg::x_payload_t x_in;
  pipe_pkg::x_payload_t x_item;
  pipe_pkg::w_payload_t w_in;
  pipe_pkg::w_payload_t w_item;
  isa_pkg::word_t       rdata1;
  isa_pkg::word_t       rdata2;
  isa_pkg::word_t       result;
  logic                 x_en;
  logic                 x_valid_in;
  logic                 x_valid;
  logic                 w_en;
  logic                 w_valid_in;
  logic                 w_valid;
  logic                 rf_wen;

  proc_ctrl ctrl (
    .clk, .reset, .inst, .inst_val, .inst_rdy,
    .mngr2proc_val, .mngr2proc_rdy, .proc2mngr_rdy, .proc2mngr_val, .commit,
    .inst_d, .dec_ctrl,
    .x_en, .x_valid_in, .x_valid,
    .x_waddr  (x_item.waddr),
    .x_rf_wen (x_item.ctrl.rf_wen),
    .w_en, .w_valid_in, .w_valid,
    .w_waddr        (w_item.waddr),
    .w_rf_wen       (w_item.rf_wen),
    .w_proc2mngr_wr (w_item.proc2mngr_wr),
    .rf_wen
  );

  reg_file rf (
    .clk,
    .raddr1 (inst_d[19:15]),
    .raddr2 (inst_d[24:20]),
    .rdata1, .rdata2,
    .wen    (rf_wen),
    .waddr  (w_item.waddr),
    .wdata  (w_item.result)
  );

  // ------------------------------------------------
  // D to X
  // ------------------------------------------------
  assign x_in.ctrl  = dec_ctrl;
  assign x_in.waddr = inst_d[11:7];
  assign x_in.op1   = rdata1;
  assign x_in.rs2   = rdata2;
  assign x_in.imm   = {{20{inst_d[31]}}, inst_d[31:20]};
  assign x_in.csr   = mngr2proc_msg;

  stage_reg #(.payload_t(pipe_pkg::x_payload_t)) x_stage (
    .clk, .reset, .en(x_en), .valid_in(x_valid_in), .payload_in(x_in),
    .valid(x_valid), .payload(x_item)
  );

  exec_alu #(.num_cores(num_cores), .core_id(core_id)) alu (
    .x_item, .result
  );

  // ------------------------------------------------
  // X to W
  // ------------------------------------------------
  assign w_in.waddr        = x_item.waddr;
  assign w_in.rf_wen       = x_item.ctrl.rf_wen;
  assign w_in.proc2mngr_wr = x_item.ctrl.proc2mngr_wr;
  assign w_in.result       = result;

  stage_reg #(.payload_t(pipe_pkg::w_payload_t)) w_stage (
    .clk, .reset, .en(w_en), .valid_in(w_valid_in), .payload_in(w_in),
    .valid(w_valid), .payload(w_item)
  );

  assign proc2mngr_msg = w_item.result;

endmodule

`default_nettype wire

// ==== verilog/reg_file.sv ====
`timescale 1ns/100ps
`default_nettype none
// ------------------------------------------------
// 32 x 32 register file, two combinational reads, one write port
// ------------------------------------------------

module reg_file (
  input  wire logic               clk,
  input  wire isa_pkg::reg_addr_t raddr1,
  input  wire isa_pkg::reg_addr_t raddr2,
  output isa_pkg::word_t          rdata1,
  output isa_pkg::word_t          rdata2,
  input  wire logic               wen,
  input  wire isa_pkg::reg_addr_t waddr,
  input  wire isa_pkg::word_t     wdata
);

  isa_pkg::word_t regs [32];

  // write lands at the edge, reads in the same cycle still see the old value
  always_ff @(posedge clk) begin
    if (wen && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  // x0 is hardwired to zero
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// ==== verilog/stage_reg.sv ====
`timescale 1ns/100ps
`default_nettype none
// ------------------------------------------------
// pipeline register holding a valid bit and a payload of any packed type
// both load on en and hold otherwise
// ------------------------------------------------

module stage_reg #(
  parameter type payload_t = logic
) (
  input  wire logic     clk,
  input  wire logic     reset,
  input  wire logic     en,
  input  wire logic     valid_in,
  input  wire payload_t payload_in,
  output logic          valid,
  output payload_t      payload
);

  always_ff @(posedge clk) begin
    if (reset) begin
      valid <= 1'b0;
    end else if (en) begin
      valid <= valid_in;
    end
  end

  // payload loads on the same enable as the valid bit
  always_ff @(posedge clk) begin
    if (en) begin
      payload <= payload_in;
    end
  end

endmodule

`default_nettype wire
